// ==== logic/spu_settings.svh ====
`ifndef SPU_SETTINGS_SVH
`define SPU_SETTINGS_SVH

// sprite attribute slots walked per line
`define SPU_SPRITE_COUNT 8

// visible pixels per line, also depth of each line buffer half
`define SPU_LINE_PIXELS 256

// clocks per output pixel
`define SPU_PIXEL_DIV 4

// 16-bit words in the shared pixel memory
`define SPU_MEM_WORDS 4096

`endif

// ==== logic/spu_pkg.sv ====
`include "spu_settings.svh"

package spu_pkg;

	typedef logic [$clog2(`SPU_SPRITE_COUNT)-1:0] sprite_idx_t;	// sprite number
	typedef logic [8:0] line_t;	// screen line or x position
	typedef logic [$clog2(`SPU_MEM_WORDS)-1:0] mem_addr_t;	// pixel word address
	typedef logic [15:0] mem_word_t;	// four 4-bit colour indices, high nibble leftmost
	typedef logic [5:0] pixel_t;	// palette select above colour index

	// one line buffer location
	typedef struct packed {
		logic   opaque;	// low means transparent
		pixel_t pixel;
	} lb_entry_t;

	typedef struct packed {
		logic       active;
		line_t      ypos;	// first covered line
		logic [6:0] ysize;	// lines covered
		line_t      xpos;	// x of leftmost pixel
		logic [6:0] xwords;	// width in 4-pixel words
		mem_addr_t  base;	// word address of the sprite's first line
		logic [1:0] palette;
	} sprite_attr_t;

	typedef struct packed {
		logic      we;
		mem_addr_t addr;
		mem_word_t wdata;
	} mem_req_t;

	typedef enum logic [2:0] {
		st_idle,
		st_attr,
		st_check,
		st_fetch,
		st_wait_data,
		st_write_pix,
		st_next_word,
		st_next_sprite
	} eng_state_t;

endpackage

// ==== logic/sprite_attr_file.sv ====
`timescale 1ns/100ps
`include "spu_settings.svh"

module sprite_attr_file (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  attr_we,
	input  spu_pkg::sprite_idx_t  attr_index,
	input  spu_pkg::sprite_attr_t attr_data,
	input  spu_pkg::sprite_idx_t  eng_index,
	output spu_pkg::sprite_attr_t engine_attr
);
	import spu_pkg::*;

	sprite_attr_t attr_q [`SPU_SPRITE_COUNT];	// attribute words
	logic [`SPU_SPRITE_COUNT-1:0] active_q;	// enables kept apart so reset can clear them

	// every sprite comes up disabled
	always_ff @(posedge clk)
	begin
		if (reset)
			active_q <= '0;
		else if (attr_we)
			active_q[attr_index] <= attr_data.active;
	end

	always_ff @(posedge clk)
	begin
		if (attr_we)
			attr_q[attr_index] <= attr_data;	// host load
	end

	// engine read port, no latency
	always_comb
	begin
		engine_attr = attr_q[eng_index];
		engine_attr.active = active_q[eng_index];	// active bit from the reset-cleared copy
	end

	// host must only address slots that exist
	a_attr_index_range: assert property (@(posedge clk) disable iff (reset)
		attr_we |-> (attr_index < `SPU_SPRITE_COUNT))
		else $error("attr_index %0d out of range", attr_index);

endmodule

// ==== logic/pixel_ram.sv ====
`timescale 1ns/100ps
`include "spu_settings.svh"

module pixel_ram (
	input  logic               clk,
	input  logic               ram_en,
	input  spu_pkg::mem_req_t  ram_req,
	output spu_pkg::mem_word_t mem_rdata
);
	import spu_pkg::*;

	mem_word_t mem [`SPU_MEM_WORDS];	// sprite pixel words

	// single port, write or read per enabled cycle
	// read data shows up one clock after the request
	always_ff @(posedge clk)
	begin
		if (ram_en)
		begin
			if (ram_req.we)
				mem[ram_req.addr] <= ram_req.wdata;	// host write
			else
				mem_rdata <= mem[ram_req.addr];	// engine fetch
		end
	end

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter (
	input  logic              clk,
	input  logic              reset,
	input  spu_pkg::mem_req_t host_req,
	input  logic              host_valid,
	input  spu_pkg::mem_req_t eng_req,
	input  logic              eng_req_valid,
	output logic              eng_grant,
	output spu_pkg::mem_req_t ram_req,
	output logic              ram_en
);
	import spu_pkg::*;

	// host always wins and the engine takes the free cycles
	assign eng_grant = eng_req_valid && !host_valid;
	assign ram_en = host_valid || eng_req_valid;

	always_comb
	begin
		if (host_valid)
			ram_req = host_req;
		else
			ram_req = eng_req;	// also the idle value while ram_en is low
	end

	// a grant ends the fetch request so a stale request is never granted again
	a_grant_ends_req: assert property (@(posedge clk) disable iff (reset)
		eng_grant |=> !eng_req_valid)
		else $error("engine request still raised after its grant");

	// engine side only ever reads
	a_eng_read_only: assert property (@(posedge clk) disable iff (reset)
		eng_req_valid |-> !eng_req.we)
		else $error("engine request with we set");

	// a waiting engine request stays put until granted
	a_eng_req_held: assert property (@(posedge clk) disable iff (reset)
		(eng_req_valid && !eng_grant) |=> (eng_req_valid && $stable(eng_req.addr)))
		else $error("engine request dropped or changed before grant");

endmodule

// ==== logic/line_buffer.sv ====
`timescale 1ns/100ps
`include "spu_settings.svh"

module line_buffer (
	input  logic               clk,
	input  logic               reset,
	input  logic               line_start,
	input  logic               wr_en,
	input  spu_pkg::line_t     wr_x,
	input  spu_pkg::lb_entry_t wr_data,
	output spu_pkg::pixel_t    pixel,
	output logic               opaque,
	output logic               pixel_strobe
);
	import spu_pkg::*;

	localparam int LB_AW = $clog2(`SPU_LINE_PIXELS);
	localparam int DIV_W = $clog2(`SPU_PIXEL_DIV);

	pixel_t pix_mem [2][`SPU_LINE_PIXELS];	// colour payload, both halves
	logic [`SPU_LINE_PIXELS-1:0] opq_q [2];	// opaque flags, cleared on reset and behind the read

	logic             lb_sel;	// half being filled by the engine
	logic             front;	// half being shown
	logic             rd_active;
	logic [DIV_W-1:0] div_cnt;
	line_t            rd_ptr;
	logic             rd_fire;	// read and clear this clock
	logic             wr_ok;
	logic [LB_AW-1:0] wr_idx;
	logic [LB_AW-1:0] rd_idx;

	assign front = ~lb_sel;
	assign wr_ok = wr_en && (wr_x < `SPU_LINE_PIXELS);	// clip at the right edge
	assign wr_idx = wr_x[LB_AW-1:0];
	assign rd_idx = rd_ptr[LB_AW-1:0];
	assign rd_fire = rd_active && (div_cnt == DIV_W'(`SPU_PIXEL_DIV - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			lb_sel <= 1'b0;
			rd_active <= 1'b0;
			div_cnt <= '0;
			rd_ptr <= '0;
			pixel_strobe <= 1'b0;
			opaque <= 1'b0;
			opq_q[0] <= '0;
			opq_q[1] <= '0;
		end
		else
		begin
			pixel_strobe <= rd_fire;
			if (line_start)
			begin
				lb_sel <= ~lb_sel;	// last line's fill becomes the front
				rd_active <= 1'b1;
				div_cnt <= DIV_W'(1);	// first strobe PIXEL_DIV clocks on
				rd_ptr <= '0;
			end
			else if (rd_active)
			begin
				div_cnt <= rd_fire ? '0 : div_cnt + 1'b1;
				if (rd_fire)
				begin
					opaque <= opq_q[front][rd_idx];
					opq_q[front][rd_idx] <= 1'b0;	// clear behind the read
					rd_ptr <= rd_ptr + 1'b1;
					if (rd_ptr == line_t'(`SPU_LINE_PIXELS - 1))
						rd_active <= 1'b0;	// line done
				end
			end
			if (wr_ok)
				opq_q[lb_sel][wr_idx] <= wr_data.opaque;	// engine fills back half
		end
	end

	// payload side, transparent locations read back as zero
	always_ff @(posedge clk)
	begin
		if (wr_ok)
			pix_mem[lb_sel][wr_idx] <= wr_data.pixel;
		if (rd_fire)
			pixel <= opq_q[front][rd_idx] ? pix_mem[front][rd_idx] : '0;
	end

endmodule

// ==== logic/sprite_engine.sv ====
`timescale 1ns/100ps
`include "spu_settings.svh"

module sprite_engine (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  frame_start,
	input  logic                  line_start,
	input  spu_pkg::sprite_attr_t engine_attr,
	output spu_pkg::sprite_idx_t  eng_index,
	output spu_pkg::mem_req_t     eng_req,
	output logic                  eng_req_valid,
	input  logic                  eng_grant,
	input  spu_pkg::mem_word_t    mem_rdata,
	output logic                  wr_en,
	output spu_pkg::line_t        wr_x,
	output spu_pkg::lb_entry_t    wr_data,
	output logic                  busy
);
	import spu_pkg::*;

	eng_state_t   state;
	line_t        line_q;	// line being built
	sprite_attr_t attr_q;	// attributes of sprite eng_index
	mem_addr_t    offs_q [`SPU_SPRITE_COUNT];	// word offset carried from line to line
	mem_addr_t    word_offs;	// running offset inside the current sprite
	logic [6:0]   words_left;
	logic [9:0]   x_q;	// top bit flags a run past x=511
	logic [1:0]   nib_cnt;
	mem_word_t    word_q;	// fetched word, shifted left per pixel
	logic [9:0]   y_end;	// one past the last covered line
	logic         y_hit;
	logic [3:0]   nib;

	assign y_end = {1'b0, attr_q.ypos} + {3'b000, attr_q.ysize};
	assign y_hit = attr_q.active && (line_q >= attr_q.ypos) && ({1'b0, line_q} < y_end);
	assign nib = word_q[15:12];	// leftmost pixel of what is left

	assign busy = (state != st_idle);
	assign eng_req_valid = (state == st_fetch);	// held until granted

	always_comb
	begin
		eng_req = '0;	// reads only
		eng_req.addr = attr_q.base + word_offs;
	end

	// frame_start comes with the first line_start of a frame
	always_ff @(posedge clk)
	begin
		if (reset)
			line_q <= '0;
		else if (line_start)
			line_q <= frame_start ? '0 : line_q + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			eng_index <= '0;
			wr_en <= 1'b0;
		end
		else
		begin
			wr_en <= 1'b0;
			case (state)
			st_idle:
				if (line_start)
				begin
					eng_index <= '0;	// walk sprites from 0 upward
					state <= st_attr;
				end
			st_attr:
			begin
				attr_q <= engine_attr;
				state <= st_check;
			end
			st_check:
				if (y_hit && (attr_q.xwords != 7'd0))
				begin
					// first covered line restarts at the sprite base
					word_offs <= (line_q == attr_q.ypos) ? '0 : offs_q[eng_index];
					words_left <= attr_q.xwords;
					x_q <= {1'b0, attr_q.xpos};
					state <= st_fetch;
				end
				else
					state <= st_next_sprite;	// inactive or not on this line
			st_fetch:
				if (eng_grant)
					state <= st_wait_data;	// host may hold us here
			st_wait_data:
			begin
				word_q <= mem_rdata;	// one clock after the grant
				nib_cnt <= 2'd0;
				state <= st_write_pix;
			end
			st_write_pix:
			begin
				// zero index is transparent, leave the buffer alone
				wr_en <= (nib != 4'h0) && !x_q[9];
				wr_x <= x_q[8:0];
				wr_data <= '{opaque: 1'b1, pixel: {attr_q.palette, nib}};
				x_q <= x_q + 10'd1;
				word_q <= {word_q[11:0], 4'h0};
				nib_cnt <= nib_cnt + 2'd1;
				if (nib_cnt == 2'd3)
					state <= st_next_word;
			end
			st_next_word:
			begin
				word_offs <= word_offs + 1'b1;
				words_left <= words_left - 7'd1;
				if (words_left == 7'd1)
				begin
					offs_q[eng_index] <= word_offs + 1'b1;	// next line picks up here
					state <= st_next_sprite;
				end
				else
					state <= st_fetch;
			end
			st_next_sprite:
				if (eng_index == sprite_idx_t'(`SPU_SPRITE_COUNT - 1))
					state <= st_idle;	// all sprites done, busy falls
				else
				begin
					eng_index <= eng_index + 1'b1;	// later sprites paint over earlier
					state <= st_attr;
				end
			default:
				state <= st_idle;
			endcase
		end
	end

	// the whole sprite walk has to fit in one line period
	a_idle_at_line_start: assert property (@(posedge clk) disable iff (reset)
		line_start |-> !busy)
		else $error("line_start while engine busy, state %s", state.name());

endmodule

// ==== logic/sprite_unit.sv ====
`timescale 1ns/100ps

module sprite_unit (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  frame_start,
	input  logic                  line_start,
	input  logic                  attr_we,
	input  spu_pkg::sprite_idx_t  attr_index,
	input  spu_pkg::sprite_attr_t attr_data,
	input  logic                  host_we,
	input  spu_pkg::mem_addr_t    host_addr,
	input  spu_pkg::mem_word_t    host_wdata,
	output spu_pkg::pixel_t       pixel,
	output logic                  opaque,
	output logic                  pixel_strobe,
	output logic                  busy
);
	import spu_pkg::*;

	sprite_idx_t  eng_index;
	sprite_attr_t engine_attr;
	mem_req_t     host_req;
	mem_req_t     eng_req;
	mem_req_t     ram_req;
	logic         eng_req_valid;
	logic         eng_grant;
	logic         ram_en;
	mem_word_t    mem_rdata;
	logic         wr_en;
	line_t        wr_x;
	lb_entry_t    wr_data;

	assign host_req = '{we: host_we, addr: host_addr, wdata: host_wdata};	// host only writes

	sprite_attr_file attr_file0 (.clk, .reset, .attr_we, .attr_index, .attr_data,
		.eng_index, .engine_attr);

	pixel_ram ram0 (.clk, .ram_en, .ram_req, .mem_rdata);

	mem_arbiter arb0 (.clk, .reset, .host_req, .host_valid(host_we), .eng_req,
		.eng_req_valid, .eng_grant, .ram_req, .ram_en);

	line_buffer lbuf0 (.clk, .reset, .line_start, .wr_en, .wr_x, .wr_data,
		.pixel, .opaque, .pixel_strobe);

	sprite_engine engine0 (.clk, .reset, .frame_start, .line_start, .engine_attr,
		.eng_index, .eng_req, .eng_req_valid, .eng_grant, .mem_rdata,
		.wr_en, .wr_x, .wr_data, .busy);

endmodule

// ==== tb/sprite_unit_tb.sv ====
`timescale 1ns/100ps
`include "spu_settings.svh"

module sprite_unit_tb;
	import spu_pkg::*;

	localparam int ROWS = 5;
	localparam int LINE_CLKS = 1100;	// clocks between line_start pulses and above 256*4
	localparam int LOAD_CLKS = 200;	// room for attribute and word loads per row

	// one stimulus row where host_line 0 means no host traffic during a busy line
	typedef struct packed {
		sprite_idx_t  ia;
		sprite_attr_t aa;	// sprite that host_line writes target
		sprite_idx_t  ib;
		sprite_attr_t ab;
		mem_word_t    key;	// fill pattern seed
		mem_word_t    mask;	// forces some nibbles to zero
		int           lines;	// lines per frame
		int           frames;
		int           host_line;
	} row_t;

	logic         clk = 1'b0;
	logic         reset;
	logic         frame_start;
	logic         line_start;
	logic         attr_we;
	sprite_idx_t  attr_index;
	sprite_attr_t attr_data;
	logic         host_we;
	mem_addr_t    host_addr;
	mem_word_t    host_wdata;
	pixel_t       pixel;
	logic         opaque;
	logic         pixel_strobe;
	logic         busy;

	sprite_attr_t attr_model [`SPU_SPRITE_COUNT];	// what the host loaded
	mem_word_t    mem_model [`SPU_MEM_WORDS];
	lb_entry_t    exp_next [`SPU_LINE_PIXELS];	// line built during this period
	lb_entry_t    exp_cur [`SPU_LINE_PIXELS];	// line shown during this period
	lb_entry_t    want;
	row_t         rows [ROWS];
	string        names [ROWS];
	int           mon_err [ROWS];	// monitor side failures per test
	int           drv_err [ROWS];	// driver side failures per test
	int           cur_owner;
	int           next_owner;
	int           line_seq;	// bumped by the driver at every line_start
	int           seen_seq;	// last line_seq the monitor counted strobes for
	int           strobe_cnt;
	int           n_checks;
	int           wd_limit;
	integer       seed = 94;

	sprite_unit dut0 (.clk, .reset, .frame_start, .line_start, .attr_we, .attr_index,
		.attr_data, .host_we, .host_addr, .host_wdata, .pixel, .opaque, .pixel_strobe, .busy);

	always #4 clk = ~clk;	// 8 ns period

	function automatic sprite_attr_t make_attr(input bit act, input int ypos, input int ysize,
		input int xpos, input int xwords, input int base, input int pal);
		sprite_attr_t a;
		a.active = act;
		a.ypos = line_t'(ypos);
		a.ysize = 7'(ysize);
		a.xpos = line_t'(xpos);
		a.xwords = 7'(xwords);
		a.base = mem_addr_t'(base);
		a.palette = 2'(pal);
		return a;
	endfunction

	// every address bit moves the word
	function automatic mem_word_t fill_word(input mem_addr_t addr, input mem_word_t key);
		return ({4'h0, addr} * 16'h9e37) ^ {addr[3:0], addr} ^ key;
	endfunction

	// expected line where later sprites paint over earlier ones
	function automatic void build_expected(input int line_no);
		sprite_attr_t a;
		mem_addr_t    addr;
		mem_word_t    w;
		int           x;
		for (int i = 0; i < `SPU_LINE_PIXELS; i++)
			exp_next[i] = '0;
		for (int s = 0; s < `SPU_SPRITE_COUNT; s++)
		begin
			a = attr_model[s];
			if (a.active && line_no >= int'(a.ypos) && line_no < int'(a.ypos) + int'(a.ysize))
			begin
				for (int k = 0; k < int'(a.xwords); k++)
				begin
					addr = a.base + mem_addr_t'((line_no - int'(a.ypos)) * int'(a.xwords) + k);
					w = mem_model[addr];
					for (int n = 0; n < 4; n++)
					begin
						x = int'(a.xpos) + 4 * k + n;	// high nibble is leftmost
						if (w[15:12] != 4'h0 && x < `SPU_LINE_PIXELS)
							exp_next[x] = '{opaque: 1'b1, pixel: {a.palette, w[15:12]}};
						w = w << 4;
					end
				end
			end
		end
	endfunction

	task automatic line_fault(input string msg);
		$display("%s", msg);
		drv_err[cur_owner]++;
	endtask

	task automatic host_write(input mem_addr_t addr, input mem_word_t data);
		host_we = 1'b1;
		host_addr = addr;
		host_wdata = data;
		mem_model[addr] = data;
		@(negedge clk);
		host_we = 1'b0;
	endtask

	task automatic write_attr(input sprite_idx_t idx, input sprite_attr_t a);
		attr_we = 1'b1;
		attr_index = idx;
		attr_data = a;
		attr_model[idx] = a;
		@(negedge clk);
		attr_we = 1'b0;
	endtask

	// all lines of a sprite sit back to back from base
	task automatic load_words(input sprite_attr_t a, input mem_word_t key, input mem_word_t mask);
		mem_addr_t addr;
		for (int i = 0; i < int'(a.ysize) * int'(a.xwords); i++)
		begin
			addr = a.base + mem_addr_t'(i);
			host_write(addr, fill_word(addr, key) & mask);
		end
	endtask

	task automatic load_row(input int r);
		@(negedge clk);
		for (int s = 0; s < `SPU_SPRITE_COUNT; s++)
			write_attr(sprite_idx_t'(s), '0);	// start from an empty sprite file
		write_attr(rows[r].ia, rows[r].aa);
		write_attr(rows[r].ib, rows[r].ab);
		load_words(rows[r].aa, rows[r].key, rows[r].mask);
		load_words(rows[r].ab, rows[r].key, rows[r].mask);
		next_owner = r;	// pending readout now counts for this test
	endtask

	// one line period in which the readout shows the line built in the period before
	task automatic run_line(input int line_no, input bit first, input bit host_busy, input int r);
		int cyc;
		int cnt;
		@(negedge clk);
		exp_cur = exp_next;
		cur_owner = next_owner;
		line_seq++;
		frame_start = first;
		line_start = 1'b1;
		@(negedge clk);
		frame_start = 1'b0;
		line_start = 1'b0;
		cyc = 1;
		assert (busy)
		else line_fault($sformatf("busy did not rise after line_start of line %0d", line_no));
		if (host_busy)
		begin
			// overwrite the sprite's first line words while this later line is fetched
			for (int i = 0; i < int'(rows[r].aa.xwords); i++)
			begin
				host_write(rows[r].aa.base + mem_addr_t'(i), mem_word_t'($random(seed)));
				cyc++;
			end
		end
		while (busy && cyc < LINE_CLKS)
		begin
			@(negedge clk);
			cyc++;
		end
		assert (!busy)
		else line_fault($sformatf("engine still busy at the end of line %0d", line_no));
		build_expected(line_no);
		while (cyc < LINE_CLKS - 1)
		begin
			@(negedge clk);
			cyc++;
		end
		cnt = (seen_seq == line_seq) ? strobe_cnt : 0;
		assert (cnt == `SPU_LINE_PIXELS)
		else line_fault($sformatf("readout during line %0d gave %0d pixel strobes",
			line_no, cnt));
	endtask

	// compare each strobe with the scoreboard entry at its x
	always @(negedge clk)
	begin
		if (!reset && pixel_strobe)
		begin
			if (seen_seq != line_seq)
			begin
				strobe_cnt = 0;	// first strobe of a new readout
				seen_seq = line_seq;
			end
			if (strobe_cnt < `SPU_LINE_PIXELS)
			begin
				want = exp_cur[strobe_cnt];
				n_checks++;
				assert (pixel === want.pixel)
				else
				begin
					$display("FAILED pixel x=%0d: got %h expected %h",
						strobe_cnt, pixel, want.pixel);
					mon_err[cur_owner]++;
				end
				assert (opaque === want.opaque)
				else
				begin
					$display("FAILED opaque x=%0d: got %h expected %h",
						strobe_cnt, opaque, want.opaque);
					mon_err[cur_owner]++;
				end
			end
			strobe_cnt++;
		end
	end

	initial
	begin
		wait (wd_limit > 0);
		repeat (wd_limit) @(posedge clk);
		$display("timeout: the run did not end within %0d clocks", wd_limit);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		int total;
		int errs;
		int tot_err;
		int n_pass;
		int n_fail;
		reset = 1'b1;
		frame_start = 1'b0;
		line_start = 1'b0;
		attr_we = 1'b0;
		attr_index = '0;
		attr_data = '0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		for (int s = 0; s < `SPU_SPRITE_COUNT; s++)
			attr_model[s] = '0;
		for (int i = 0; i < `SPU_LINE_PIXELS; i++)
			exp_next[i] = '0;	// both halves come up transparent

		names[0] = "hidden sprites";
		rows[0] = '{ia: 3'd2, aa: make_attr(0, 0, 4, 10, 2, 0, 1), ib: 3'd5,
			ab: make_attr(1, 20, 2, 40, 2, 16, 3), key: 16'h1357, mask: 16'hffff,
			lines: 4, frames: 1, host_line: 0};
		names[1] = "nibbles and clip";
		rows[1] = '{ia: 3'd1, aa: make_attr(1, 1, 2, 248, 4, 100, 2), ib: 3'd7,
			ab: make_attr(0, 0, 1, 0, 1, 150, 0), key: 16'h2468, mask: 16'hf0ff,
			lines: 4, frames: 1, host_line: 0};	// line 3 reads back blank
		names[2] = "word offset";
		rows[2] = '{ia: 3'd0, aa: make_attr(1, 0, 3, 0, 3, 200, 3), ib: 3'd4,
			ab: make_attr(0, 0, 1, 0, 1, 250, 0), key: 16'h5a5a, mask: 16'hffff,
			lines: 4, frames: 2, host_line: 0};
		names[3] = "overlap priority";
		rows[3] = '{ia: 3'd6, aa: make_attr(1, 1, 2, 29, 2, 300, 1), ib: 3'd3,
			ab: make_attr(1, 0, 3, 26, 3, 400, 2), key: 16'hc3c3, mask: 16'hf00f,
			lines: 4, frames: 1, host_line: 0};
		names[4] = "host while busy";
		rows[4] = '{ia: 3'd0, aa: make_attr(1, 0, 3, 64, 4, 500, 0), ib: 3'd5,
			ab: make_attr(0, 0, 1, 0, 1, 600, 0), key: 16'h0ff0, mask: 16'hffff,
			lines: 4, frames: 2, host_line: 2};	// sprite 0 fetches while the host writes

		total = 0;
		for (int r = 0; r < ROWS; r++)
			total += rows[r].frames * rows[r].lines + 1;	// plus one flush line per row
		wd_limit = total * LINE_CLKS + ROWS * LOAD_CLKS + 64;

		repeat (16) @(negedge clk);
		reset = 1'b0;

		n_pass = 0;
		n_fail = 0;
		tot_err = 0;
		for (int r = 0; r < ROWS; r++)
		begin
			load_row(r);
			for (int f = 0; f < rows[r].frames; f++)
				for (int l = 0; l < rows[r].lines; l++)
					run_line(l, l == 0, f == 0 && rows[r].host_line != 0 && l == rows[r].host_line, r);
			run_line(rows[r].lines, 1'b0, 1'b0, r);	// shows the last line of the frame
			errs = mon_err[r] + drv_err[r];
			tot_err += errs;
			if (errs == 0)
				n_pass++;
			else
				n_fail++;
			$display("test %0d %s: %s, %0d errors", r, names[r], (errs == 0) ? "ok" : "bad", errs);
		end

		$display("%0d tests, %0d passed, %0d failed, %0d pixel checks, %0d errors",
			ROWS, n_pass, n_fail, n_checks, tot_err);
		if (tot_err == 0 && n_fail == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== sprite_unit.f ====
+incdir+logic
logic/spu_pkg.sv
logic/sprite_attr_file.sv
logic/pixel_ram.sv
logic/mem_arbiter.sv
logic/line_buffer.sv
logic/sprite_engine.sv
logic/sprite_unit.sv
tb/sprite_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the sprite unit testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module sprite_unit_tb -f sprite_unit.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vsprite_unit_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# only the pass line counts as success
if grep -q "^Simulation finished: PASS$" "$LOG"; then
	exit 0
fi
exit 1
